//--- source/exec_issue_stage.sv
// operand capture register between issue and the ALU, drops younger micro-ops on a redirect
`default_nettype none

module exec_issue_stage #(
  parameter int TAG_W = 6
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      issue_valid_i,
  input  exec_pkg::uop_t            issue_uop_i,
  input  logic [exec_pkg::XLEN-1:0] rs1_data_i,
  input  logic [exec_pkg::XLEN-1:0] rs2_data_i,
  input  logic [TAG_W-1:0]          rob_tag_i,
  exec_uop_if.issue                 uop_o,
  exec_wb_if.issue                  wb_i
);

  logic                      accept;
  logic                      valid_q;
  exec_pkg::uop_t            uop_q;
  logic [exec_pkg::XLEN-1:0] rs1_q;
  logic [exec_pkg::XLEN-1:0] rs2_q;
  logic [TAG_W-1:0]          tag_q;

  // no issue accepted while a redirect is in writeback
  assign accept = issue_valid_i & ~wb_i.squash;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= accept;
    end
  end

  // payload only moves on an accepted issue
  always_ff @(posedge clk_i) begin
    if (accept) begin
      uop_q <= issue_uop_i;
      rs1_q <= rs1_data_i;
      rs2_q <= rs2_data_i;
      tag_q <= rob_tag_i;
    end
  end

  // held micro-op is younger than the redirecting one, kill it here
  assign uop_o.valid    = valid_q & ~wb_i.squash;
  assign uop_o.uop      = uop_q;
  assign uop_o.rs1_data = rs1_q;
  assign uop_o.rs2_data = rs2_q;
  assign uop_o.rob_tag  = tag_q;

endmodule

`default_nettype wire

//--- source/exec_pkg.sv
// shared widths, opcode enums and the micro-op struct used across the integer execute cluster
`default_nettype none

package exec_pkg;

  // datapath and address widths
  localparam int XLEN = 64;
  localparam int PC_W = 39;

  // byte size of one uncompressed instruction
  localparam int INSTR_SIZE = 4;

  // alu function select
  typedef enum logic [3:0] {
    ADD   = 4'd0,
    SUB   = 4'd1,
    LUI   = 4'd2,
    AUIPC = 4'd3,
    AND   = 4'd4,
    OR    = 4'd5,
    XOR   = 4'd6,
    SLL   = 4'd7,
    SRL   = 4'd8,
    SRA   = 4'd9,
    SLT   = 4'd10,
    SLTU  = 4'd11
  } alu_op_e;

  // branch condition / jump kind
  typedef enum logic [2:0] {
    EQ   = 3'd0,
    NE   = 3'd1,
    LT   = 3'd2,
    GE   = 3'd3,
    LTU  = 3'd4,
    GEU  = 3'd5,
    JAL  = 3'd6,
    JALR = 3'd7
  } br_op_e;

  // decoded micro-op, 114 bits
  typedef struct packed {
    alu_op_e           alu_op;
    br_op_e            br_op;
    logic              is_branch;
    logic              is_jump;
    logic              is_word_op;
    logic              has_rs2;
    logic [XLEN-1:0]   imm;
    logic [PC_W-1:0]   pc;
  } uop_t;

endpackage

`default_nettype wire

//--- source/exec_top.sv
// top of the integer execute cluster, issue register -> ALU -> writeback register
`default_nettype none

module exec_top #(
  parameter int TAG_W = 6
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  // issue side
  input  logic                      issue_valid_i,
  input  exec_pkg::uop_t            issue_uop_i,
  input  logic [exec_pkg::XLEN-1:0] rs1_data_i,
  input  logic [exec_pkg::XLEN-1:0] rs2_data_i,
  input  logic [TAG_W-1:0]          rob_tag_i,

  // writeback and control flow
  output logic                      wb_valid_o,
  output logic [TAG_W-1:0]          wb_tag_o,
  output logic [exec_pkg::XLEN-1:0] wb_result_o,
  output logic                      redirect_valid_o,
  output logic [exec_pkg::PC_W-1:0] redirect_pc_o
);

  exec_uop_if #(.TAG_W(TAG_W)) uop_if ();
  exec_wb_if  #(.TAG_W(TAG_W)) wb_if ();

  exec_issue_stage #(
    .TAG_W(TAG_W)
  ) u_issue (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .issue_valid_i(issue_valid_i),
    .issue_uop_i  (issue_uop_i),
    .rs1_data_i   (rs1_data_i),
    .rs2_data_i   (rs2_data_i),
    .rob_tag_i    (rob_tag_i),
    .uop_o        (uop_if.issue),
    .wb_i         (wb_if.issue)
  );

  // purely combinational, result lands in writeback one edge later
  execute_alu #(
    .TAG_W(TAG_W)
  ) u_alu (
    .uop_i(uop_if.alu),
    .res_o(wb_if.alu)
  );

  exec_wb_stage #(
    .TAG_W(TAG_W)
  ) u_wb (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .alu_i           (wb_if.wb),
    .wb_valid_o      (wb_valid_o),
    .wb_tag_o        (wb_tag_o),
    .wb_result_o     (wb_result_o),
    .redirect_valid_o(redirect_valid_o),
    .redirect_pc_o   (redirect_pc_o)
  );

endmodule

`default_nettype wire

//--- source/exec_uop_if.sv
// issued micro-op bundle from the operand register to the ALU, instantiated in the cluster top
`default_nettype none

interface exec_uop_if #(
  parameter int TAG_W = 6
);

  // valid is a level, fields are live while it is high
  logic                      valid;
  exec_pkg::uop_t            uop;
  logic [exec_pkg::XLEN-1:0] rs1_data;
  logic [exec_pkg::XLEN-1:0] rs2_data;
  logic [TAG_W-1:0]          rob_tag;

  modport issue (
    output valid, uop, rs1_data, rs2_data, rob_tag
  );

  modport alu (
    input valid, uop, rs1_data, rs2_data, rob_tag
  );

endinterface

`default_nettype wire

//--- source/exec_wb_if.sv
// ALU result bundle into the writeback register plus the squash pulse back to issue
`default_nettype none

interface exec_wb_if #(
  parameter int TAG_W = 6
);

  logic                      alu_valid;
  logic [TAG_W-1:0]          alu_tag;
  logic [exec_pkg::XLEN-1:0] alu_result;
  logic                      alu_mispred;
  logic [exec_pkg::PC_W-1:0] alu_redirect_pc;
  // one-cycle kill, same as the registered redirect valid
  logic                      squash;

  modport alu (
    output alu_valid, alu_tag, alu_result, alu_mispred, alu_redirect_pc
  );

  modport wb (
    input  alu_valid, alu_tag, alu_result, alu_mispred, alu_redirect_pc,
    output squash
  );

  modport issue (input squash);

endinterface

`default_nettype wire

//--- source/exec_wb_stage.sv
// writeback register for ALU results and redirects, also feeds the squash pulse to issue
`default_nettype none

module exec_wb_stage #(
  parameter int TAG_W = 6
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  exec_wb_if.wb                     alu_i,
  output logic                      wb_valid_o,
  output logic [TAG_W-1:0]          wb_tag_o,
  output logic [exec_pkg::XLEN-1:0] wb_result_o,
  output logic                      redirect_valid_o,
  output logic [exec_pkg::PC_W-1:0] redirect_pc_o
);

  logic redirect_d;

  // redirect only counts for a live micro-op
  assign redirect_d = alu_i.alu_valid & alu_i.alu_mispred;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_valid_o       <= 1'b0;
      wb_tag_o         <= '0;
      wb_result_o      <= '0;
      redirect_valid_o <= 1'b0;
      redirect_pc_o    <= '0;
    end else begin
      wb_valid_o       <= alu_i.alu_valid;
      redirect_valid_o <= redirect_d;
      if (alu_i.alu_valid) begin
        wb_tag_o    <= alu_i.alu_tag;
        wb_result_o <= alu_i.alu_result;
      end
      if (redirect_d) begin
        redirect_pc_o <= alu_i.alu_redirect_pc;
      end
    end
  end

  // kill loop back to the issue register
  assign alu_i.squash = redirect_valid_o;

endmodule

`default_nettype wire

//--- source/execute_alu.sv
// combinational integer ALU with branch resolution and not-taken mispredict detection
`default_nettype none

module execute_alu #(
  parameter int TAG_W = 6
) (
  exec_uop_if.alu uop_i,
  exec_wb_if.alu  res_o
);

  localparam int SHAMT_W = $clog2(exec_pkg::XLEN);
  localparam logic [exec_pkg::PC_W-1:0] STEP = exec_pkg::PC_W'(exec_pkg::INSTR_SIZE);

  logic [exec_pkg::XLEN-1:0] op_a;
  logic [exec_pkg::XLEN-1:0] op_b;
  logic [exec_pkg::XLEN-1:0] rs1;
  logic [exec_pkg::XLEN-1:0] rs2;
  logic [31:0]               op_a_w;
  logic [31:0]               op_b_w;
  logic [31:0]               res_w;
  logic [exec_pkg::XLEN-1:0] res_d;
  logic [exec_pkg::XLEN-1:0] alu_res;
  logic [exec_pkg::XLEN-1:0] jalr_sum;
  logic [exec_pkg::PC_W-1:0] target;
  logic [exec_pkg::PC_W-1:0] link_pc;
  logic                      taken;
  logic                      mispred;
  logic [TAG_W-1:0]          tag;

  assign rs1 = uop_i.rs1_data;
  assign rs2 = uop_i.rs2_data;

  // auipc adds to the pc, everything else to rs1
  assign op_a   = (uop_i.uop.alu_op == exec_pkg::AUIPC) ?
                  exec_pkg::XLEN'(uop_i.uop.pc) : rs1;
  assign op_b   = uop_i.uop.has_rs2 ? rs2 : uop_i.uop.imm;
  assign op_a_w = op_a[31:0];
  assign op_b_w = op_b[31:0];

  // only add, sub and shifts have word forms in rv64
  always_comb begin
    case (uop_i.uop.alu_op)
      exec_pkg::ADD: res_w = op_a_w + op_b_w;
      exec_pkg::SUB: res_w = op_a_w - op_b_w;
      exec_pkg::SLL: res_w = op_a_w << op_b_w[4:0];
      exec_pkg::SRL: res_w = op_a_w >> op_b_w[4:0];
      exec_pkg::SRA: res_w = $signed(op_a_w) >>> op_b_w[4:0];
      default:       res_w = '0;
    endcase
  end

  always_comb begin
    case (uop_i.uop.alu_op)
      exec_pkg::ADD:   res_d = op_a + op_b;
      exec_pkg::SUB:   res_d = op_a - op_b;
      exec_pkg::LUI:   res_d = uop_i.uop.imm;
      exec_pkg::AUIPC: res_d = op_a + op_b;
      exec_pkg::AND:   res_d = op_a & op_b;
      exec_pkg::OR:    res_d = op_a | op_b;
      exec_pkg::XOR:   res_d = op_a ^ op_b;
      exec_pkg::SLL:   res_d = op_a << op_b[SHAMT_W-1:0];
      exec_pkg::SRL:   res_d = op_a >> op_b[SHAMT_W-1:0];
      exec_pkg::SRA:   res_d = $signed(op_a) >>> op_b[SHAMT_W-1:0];
      exec_pkg::SLT:   res_d = exec_pkg::XLEN'($signed(op_a) < $signed(op_b));
      exec_pkg::SLTU:  res_d = exec_pkg::XLEN'(op_a < op_b);
      default:         res_d = '0;
    endcase
  end

  // sign-extend bit 31 for the w forms
  assign alu_res = uop_i.uop.is_word_op ?
                   {{(exec_pkg::XLEN-32){res_w[31]}}, res_w} : res_d;

  // jalr clears bit 0 of the full sum before truncating to pc width
  assign jalr_sum = (rs1 + uop_i.uop.imm) & ~exec_pkg::XLEN'(1);
  assign target   = (uop_i.uop.br_op == exec_pkg::JALR) ?
                    jalr_sum[exec_pkg::PC_W-1:0] :
                    uop_i.uop.pc + uop_i.uop.imm[exec_pkg::PC_W-1:0];
  assign link_pc  = uop_i.uop.pc + STEP;

  always_comb begin
    taken = 1'b0;
    if (uop_i.uop.is_jump) begin
      taken = 1'b1;
    end else if (uop_i.uop.is_branch) begin
      case (uop_i.uop.br_op)
        exec_pkg::EQ:  taken = (rs1 == rs2);
        exec_pkg::NE:  taken = (rs1 != rs2);
        exec_pkg::LT:  taken = ($signed(rs1) < $signed(rs2));
        exec_pkg::GE:  taken = ($signed(rs1) >= $signed(rs2));
        exec_pkg::LTU: taken = (rs1 < rs2);
        exec_pkg::GEU: taken = (rs1 >= rs2);
        default:       taken = 1'b0;
      endcase
    end
  end

  // front end always predicts not-taken, so any taken flow is a miss
  assign mispred = uop_i.valid & taken;

  assign tag = uop_i.rob_tag;

  assign res_o.alu_valid       = uop_i.valid;
  assign res_o.alu_tag         = tag;
  assign res_o.alu_mispred     = mispred;
  assign res_o.alu_redirect_pc = mispred ? target : '0;
  // jumps return the link address, branches write nothing useful
  assign res_o.alu_result      = uop_i.uop.is_jump   ? exec_pkg::XLEN'(link_pc) :
                                 uop_i.uop.is_branch ? '0 : alu_res;

endmodule

`default_nettype wire

//--- tb.f
source/exec_pkg.sv
source/exec_uop_if.sv
source/exec_wb_if.sv
source/exec_issue_stage.sv
source/execute_alu.sv
source/exec_wb_stage.sv
source/exec_top.sv
tb/exec_top_checker.sv
tb/exec_top_tb.sv

//--- tb/exec_top_checker.sv
// concurrent pin-level checks on the execute cluster, bound into exec_top by the bind below
`default_nettype none

module exec_top_checker #(
  parameter int TAG_W = 6
) (
  input logic                      clk_i,
  input logic                      arst_n_i,
  input logic                      issue_valid_i,
  input logic [TAG_W-1:0]          rob_tag_i,
  input logic                      wb_valid_i,
  input logic [TAG_W-1:0]          wb_tag_i,
  input logic [exec_pkg::XLEN-1:0] wb_result_i,
  input logic                      redirect_valid_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // outputs held quiet while reset is applied and on the first edge after it
  reset_quiet: assert property (@(posedge clk_i)
    !arst_n_i |-> !wb_valid_i && !redirect_valid_i && wb_result_i == '0)
    else begin
      fail_count++;
      $error("outputs active during reset");
    end

  reset_exit: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> !wb_valid_i && !redirect_valid_i)
    else begin
      fail_count++;
      $error("outputs active right after reset");
    end

  redirect_has_wb: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    redirect_valid_i |-> wb_valid_i)
    else begin
      fail_count++;
      $error("redirect without writeback");
    end

  // accepted issue that sees no squash comes back two edges later with its tag
  issue_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (issue_valid_i && !redirect_valid_i) ##1 !redirect_valid_i
    |=> wb_valid_i && wb_tag_i == $past(rob_tag_i, 2))
    else begin
      fail_count++;
      $error("writeback missing or tag changed");
    end

  // held micro-op killed by the squash pulse
  squash_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (issue_valid_i && !redirect_valid_i) ##1 redirect_valid_i |=> !wb_valid_i)
    else begin
      fail_count++;
      $error("squashed micro-op reached writeback");
    end

  // idle slot, or an issue refused during squash
  no_issue_no_wb: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (!issue_valid_i || redirect_valid_i) |-> ##2 !wb_valid_i)
    else begin
      fail_count++;
      $error("writeback from an empty slot");
    end

endmodule

bind exec_top exec_top_checker #(
  .TAG_W(TAG_W)
) chk0 (
  .clk_i           (clk_i),
  .arst_n_i        (arst_n_i),
  .issue_valid_i   (issue_valid_i),
  .rob_tag_i       (rob_tag_i),
  .wb_valid_i      (wb_valid_o),
  .wb_tag_i        (wb_tag_o),
  .wb_result_i     (wb_result_o),
  .redirect_valid_i(redirect_valid_o)
);

`default_nettype wire

//--- tb/exec_top_tb.sv
// testbench for exec_top, directed and random micro-ops checked against a reference model queue
`default_nettype none

module exec_top_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PERIOD   = 100;
  localparam int N_UOPS   = 48 + 20 + 96 + 8 + 300;

  typedef struct packed {
    logic [5:0]  tag;
    logic [63:0] res;
    logic        redir;
    logic [38:0] pc;
  } exp_t;

  logic                      clk_i;
  logic                      arst_n_i;
  logic                      issue_valid_i;
  exec_pkg::uop_t            issue_uop_i;
  logic [63:0]               rs1_data_i;
  logic [63:0]               rs2_data_i;
  logic [5:0]                rob_tag_i;
  logic                      wb_valid_o;
  logic [5:0]                wb_tag_o;
  logic [63:0]               wb_result_o;
  logic                      redirect_valid_o;
  logic [38:0]               redirect_pc_o;

  exp_t        exp_q[$];
  int          errors = 0;
  int          kill_left = 0;
  logic [5:0]  tag_ctr = '0;
  integer      seed = 32'ha602_ad21;
  logic [63:0] edges [4] = '{64'd0, '1, 64'h8000_0000_0000_0000, 64'd63};
  int          word_ops [5] = '{0, 1, 7, 8, 9};

  exec_top #(.TAG_W(6)) dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD / 2) clk_i = ~clk_i;
  end

  // expected writeback from the RV64 rules
  function automatic exp_t predict(input exec_pkg::uop_t u, input logic [63:0] x,
                                   input logic [63:0] y, input logic [5:0] tag);
    exp_t        e;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    logic [63:0] sum;
    logic [31:0] w;
    a = (u.alu_op == exec_pkg::AUIPC) ? {25'd0, u.pc} : x;
    b = u.has_rs2 ? y : u.imm;
    if (u.is_word_op) begin
      case (u.alu_op)
        exec_pkg::ADD: w = a[31:0] + b[31:0];
        exec_pkg::SUB: w = a[31:0] - b[31:0];
        exec_pkg::SLL: w = a[31:0] << b[4:0];
        exec_pkg::SRL: w = a[31:0] >> b[4:0];
        default:       w = $signed(a[31:0]) >>> b[4:0];
      endcase
      r = {{32{w[31]}}, w};
    end else begin
      case (u.alu_op)
        exec_pkg::SUB:  r = a - b;
        exec_pkg::LUI:  r = u.imm;
        exec_pkg::AND:  r = a & b;
        exec_pkg::OR:   r = a | b;
        exec_pkg::XOR:  r = a ^ b;
        exec_pkg::SLL:  r = a << b[5:0];
        exec_pkg::SRL:  r = a >> b[5:0];
        exec_pkg::SRA:  r = $signed(a) >>> b[5:0];
        exec_pkg::SLT:  r = {63'd0, $signed(a) < $signed(b)};
        exec_pkg::SLTU: r = {63'd0, a < b};
        default:        r = a + b;
      endcase
    end
    case (u.br_op)
      exec_pkg::EQ:  e.redir = (x == y);
      exec_pkg::NE:  e.redir = (x != y);
      exec_pkg::LT:  e.redir = ($signed(x) < $signed(y));
      exec_pkg::GE:  e.redir = ($signed(x) >= $signed(y));
      exec_pkg::LTU: e.redir = (x < y);
      exec_pkg::GEU: e.redir = (x >= y);
      default:       e.redir = 1'b1;
    endcase
    e.redir = u.is_jump | (u.is_branch & e.redir);
    sum = x + u.imm;
    e.pc = (u.br_op == exec_pkg::JALR) ? {sum[38:1], 1'b0} : u.pc + u.imm[38:0];
    e.res = u.is_jump ? {25'd0, u.pc + 39'(exec_pkg::INSTR_SIZE)} : u.is_branch ? '0 : r;
    e.tag = tag;
    return e;
  endfunction

  // one issue slot; the two slots after a predicted redirect are lost
  task automatic send(input logic v, input exec_pkg::uop_t u, input logic [63:0] a,
                      input logic [63:0] b);
    @(posedge clk_i);
    #10;
    issue_valid_i = v;
    issue_uop_i   = u;
    rs1_data_i    = a;
    rs2_data_i    = b;
    rob_tag_i     = tag_ctr;
    if (kill_left > 0) begin
      kill_left--;
    end else if (v) begin
      exp_q.push_back(predict(u, a, b, tag_ctr));
      if (exp_q[$].redir) kill_left = 2;
    end
    if (v) tag_ctr++;
  endtask

  always @(negedge clk_i) begin : compare_wb
    exp_t e;
    if (arst_n_i && wb_valid_o) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("writeback seen with no micro-op outstanding");
      end else begin
        e = exp_q.pop_front();
        assert (wb_tag_o == e.tag) else begin
          errors++;
          $display("error wb_tag_o expected %h actual %h", e.tag, wb_tag_o);
        end
        assert (wb_result_o == e.res) else begin
          errors++;
          $display("error wb_result_o expected %h actual %h", e.res, wb_result_o);
        end
        assert (redirect_valid_o == e.redir) else begin
          errors++;
          $display("error redirect_valid_o expected %h actual %h", e.redir, redirect_valid_o);
        end
        assert (!e.redir || redirect_pc_o == e.pc) else begin
          errors++;
          $display("error redirect_pc_o expected %h actual %h", e.pc, redirect_pc_o);
        end
      end
    end
  end

  // watchdog sized from the number of micro-ops
  initial begin
    #((N_UOPS + 20) * PERIOD);
    $display("timeout: writeback stream did not drain in time");
    $display("Test failed");
    $finish;
  end

  initial begin : stimulus
    exec_pkg::uop_t u;
    logic [63:0]    a;
    logic [63:0]    b;
    logic [31:0]    r;
    issue_valid_i = 1'b0;
    issue_uop_i   = '0;
    rs1_data_i    = '0;
    rs2_data_i    = '0;
    rob_tag_i     = '0;
    arst_n_i      = 1'b1;
    #1;
    arst_n_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #10;
    arst_n_i = 1'b1;

    // every alu opcode over the edge operands, j == 0 takes the immediate
    for (int op = 0; op < 12; op++) begin
      for (int j = 0; j < 4; j++) begin
        u = '0;
        u.alu_op  = exec_pkg::alu_op_e'(op);
        u.has_rs2 = (j != 0);
        u.imm     = 64'hffff_ffff_8000_0000;
        u.pc      = 39'h7f_ffff_f000;
        send(1'b1, u, edges[(j + 2) % 4], edges[j]);
      end
    end
    // word forms with carries into bit 31
    for (int k = 0; k < 5; k++) begin
      for (int j = 0; j < 4; j++) begin
        u = '0;
        u.alu_op     = exec_pkg::alu_op_e'(word_ops[k]);
        u.is_word_op = 1'b1;
        u.has_rs2    = (j != 0);
        u.imm        = 64'd1;
        send(1'b1, u, edges[(j + 2) % 4] + 64'h7fff_ffff, edges[j]);
      end
    end
    for (int br = 0; br < 6; br++) begin
      for (int j = 0; j < 4; j++) begin
        for (int k = 0; k < 4; k++) begin
          u = '0;
          u.is_branch = 1'b1;
          u.br_op     = exec_pkg::br_op_e'(br);
          u.imm       = 64'hffff_ffff_ffff_fff0;
          u.pc        = 39'h40_0000_1000 + 39'(k * 4);
          send(1'b1, u, edges[j], edges[k]);
        end
      end
    end
    // jal wraps the link at the top of the pc space, jalr has an odd sum
    for (int j = 0; j < 4; j++) begin
      u = '0;
      u.is_jump = 1'b1;
      u.br_op   = exec_pkg::JAL;
      u.imm     = edges[j];
      u.pc      = 39'h7f_ffff_fffc;
      send(1'b1, u, edges[j], edges[j]);
      u.br_op   = exec_pkg::JALR;
      u.imm     = edges[(j + 2) % 4];
      send(1'b1, u, edges[j] + 64'd1, edges[j]);
    end

    for (int i = 0; i < 300; i++) begin
      u = '0;
      a = {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)};
      u.imm = {$random(seed), $random(seed)};
      r = $random(seed);
      u.pc = {r[6:0], $random(seed)};
      r = $random(seed);
      u.alu_op  = exec_pkg::alu_op_e'(r[23:20] % 4'd12);
      u.has_rs2 = r[0];
      if (r[4:2] == 3'd0) begin
        u.is_branch = 1'b1;
        u.br_op     = exec_pkg::br_op_e'(r[10:8] % 3'd6);
        if (r[1]) b = a;
      end else if (r[4:2] == 3'd1) begin
        u.is_jump = 1'b1;
        u.br_op   = r[1] ? exec_pkg::JALR : exec_pkg::JAL;
      end else if (r[1] && u.alu_op inside {exec_pkg::ADD, exec_pkg::SUB, exec_pkg::SLL,
                                            exec_pkg::SRL, exec_pkg::SRA}) begin
        u.is_word_op = 1'b1;
      end
      send(r[15:14] != 2'b00, u, a, b);
    end

    @(posedge clk_i);
    #10;
    issue_valid_i = 1'b0;
    while (exp_q.size() != 0) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    $display("errors %0d, assertion failures %0d", errors, dut0.chk0.fail_count);
    if (errors == 0 && dut0.chk0.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
